// File: verilog/debug_pkg.sv
// ------------------------------------------------
// shared widths, address map and types of the debug unit
// import by wildcard in the module header
// ------------------------------------------------
package debug_pkg;

  // bus and core widths
  localparam int DBG_ADDR_W = 15;
  localparam int DBG_DATA_W = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int CAUSE_W    = 6;

  localparam logic [CAUSE_W-1:0] DBG_CAUSE_HALT = 6'h1F; // non-trap halt

  // ------------------------------------------------
  // address map, region in bits 13:8, index in 6:2
  // ------------------------------------------------
  localparam logic [5:0] REGION_DBG_ALWAYS = 6'h00;
  localparam logic [5:0] REGION_DBG_HALTED = 6'h20;
  localparam logic [5:0] REGION_GPR        = 6'h04;

  localparam logic [4:0] REG_CTRL  = 5'd0;
  localparam logic [4:0] REG_HIT   = 5'd1;
  localparam logic [4:0] REG_IE    = 5'd2;
  localparam logic [4:0] REG_CAUSE = 5'd3;
  localparam logic [4:0] REG_NPC   = 5'd0; // halted-only region
  localparam logic [4:0] REG_PPC   = 5'd1;

  // register bit fields
  localparam int CTRL_HALT_BIT  = 16;
  localparam int CTRL_SSTE_BIT  = 0;
  localparam int HIT_SLEEP_BIT  = 16;
  localparam int HIT_SSTH_BIT   = 0;
  localparam int IE_ECALL_BIT   = 11;
  localparam int IE_ELSU_HI_BIT = 7;
  localparam int IE_ELSU_LO_BIT = 5;
  localparam int IE_EBRK_BIT    = 3;
  localparam int IE_EILL_BIT    = 2;

  typedef struct packed {
    logic sste;  // single-step enable
    logic ecall;
    logic elsu;  // load/store fault, both IE bits
    logic ebrk;
    logic eill;
  } settings_t;

  typedef enum logic [1:0] {RD_NONE, RD_GPR, RD_DBGA, RD_DBGS} rdata_sel_e;
  typedef enum logic [1:0] {RUNNING, HALT_REQ, HALT} halt_state_e;
  typedef enum logic [1:0] {IFID, IFEX, IDEX} pc_track_e;

endpackage

// File: verilog/debug_access_decode.sv
// ------------------------------------------------
// debug bus decoder, grants every access and holds settings
// ------------------------------------------------
`timescale 1ns/1ps

module debug_access_decode import debug_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  debug_req_i,
  input  logic                  debug_we_i,
  input  logic [DBG_ADDR_W-1:0] debug_addr_i,
  input  logic [DBG_DATA_W-1:0] debug_wdata_i,
  input  logic                  halted_i,
  output logic                  debug_gnt_o,
  output rdata_sel_e            rdata_sel_o,
  output logic [4:0]            addr_idx_o,
  output settings_t             settings_o,
  output logic                  halt_wr_o,
  output logic                  resume_wr_o,
  output logic                  ssth_clr_o,
  output logic                  jump_req_o,
  output logic [DBG_DATA_W-1:0] jump_addr_o,
  output logic                  regfile_rreq_o,
  output logic [GPR_ADDR_W-1:0] regfile_raddr_o,
  output logic                  regfile_wreq_o,
  output logic [GPR_ADDR_W-1:0] regfile_waddr_o,
  output logic [DBG_DATA_W-1:0] regfile_wdata_o
);

  logic [5:0]            region;
  logic [4:0]            idx;
  logic [4:0]            addr_idx_q;     // latched word index
  logic [DBG_DATA_W-1:0] wdata_q;        // npc target
  logic                  req_q;          // high in the rvalid cycle
  rdata_sel_e            rdata_sel_q, rdata_sel_n;
  logic                  regfile_rreq_q, regfile_rreq_n;
  logic                  jump_req_q, jump_req_n;
  settings_t             settings_q, settings_n;

  assign region = debug_addr_i[13:8];
  assign idx    = debug_addr_i[6:2];

  // ------------------------------------------------
  // access decode
  // ------------------------------------------------
  always_comb begin
    rdata_sel_n    = RD_NONE;
    regfile_rreq_n = 1'b0;
    regfile_wreq_o = 1'b0;
    jump_req_n     = 1'b0;
    halt_wr_o      = 1'b0;
    resume_wr_o    = 1'b0;
    ssth_clr_o     = 1'b0;
    settings_n     = settings_q;

    // bit 14 is the csr region, granted and ignored
    if (debug_req_i && !debug_addr_i[14]) begin
      if (debug_we_i) begin
        case (region)
          REGION_DBG_ALWAYS: begin
            case (idx)
              REG_CTRL: begin
                if (debug_wdata_i[CTRL_HALT_BIT])
                  halt_wr_o = !halted_i;  // halt only a running core
                else
                  resume_wr_o = halted_i;
                settings_n.sste = debug_wdata_i[CTRL_SSTE_BIT];
              end
              REG_HIT: ssth_clr_o = debug_wdata_i[HIT_SSTH_BIT]; // write 1 to clear
              REG_IE: begin
                settings_n.ecall = debug_wdata_i[IE_ECALL_BIT];
                settings_n.elsu  = debug_wdata_i[IE_ELSU_HI_BIT] |
                                   debug_wdata_i[IE_ELSU_LO_BIT];
                settings_n.ebrk  = debug_wdata_i[IE_EBRK_BIT];
                settings_n.eill  = debug_wdata_i[IE_EILL_BIT];
              end
              default: ;
            endcase
          end
          REGION_DBG_HALTED: jump_req_n = halted_i && (idx == REG_NPC);
          REGION_GPR:        regfile_wreq_o = halted_i;
          default: ;
        endcase
      end else begin
        case (region)
          REGION_DBG_ALWAYS: rdata_sel_n = RD_DBGA;
          REGION_DBG_HALTED: if (halted_i) rdata_sel_n = RD_DBGS; // npc/ppc
          REGION_GPR: begin
            if (halted_i) begin
              regfile_rreq_n = 1'b1;
              rdata_sel_n    = RD_GPR;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q     <= '0;
      req_q          <= 1'b0;
      rdata_sel_q    <= RD_NONE;
      regfile_rreq_q <= 1'b0;
      jump_req_q     <= 1'b0;
    end else begin
      settings_q <= settings_n;
      req_q      <= debug_req_i;
      // load on request or rvalid so each pulse fires once
      if (debug_req_i || req_q) begin
        rdata_sel_q    <= rdata_sel_n;
        regfile_rreq_q <= regfile_rreq_n;
        jump_req_q     <= jump_req_n;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      addr_idx_q <= idx;
      wdata_q    <= debug_wdata_i;
    end
  end

  assign debug_gnt_o     = debug_req_i;   // no back-pressure
  assign rdata_sel_o     = rdata_sel_q;
  assign addr_idx_o      = addr_idx_q;
  assign settings_o      = settings_q;
  assign jump_req_o      = jump_req_q;
  assign jump_addr_o     = wdata_q;
  assign regfile_rreq_o  = regfile_rreq_q;
  assign regfile_raddr_o = addr_idx_q;
  assign regfile_waddr_o = idx;           // write goes out in the grant cycle
  assign regfile_wdata_o = debug_wdata_i;

  // debugger issues word accesses only
  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    debug_req_i |-> (debug_addr_i[1:0] == 2'b00))
    else $error("unaligned debug access");

endmodule

// File: verilog/debug_halt_ctrl.sv
// ------------------------------------------------
// halt/resume handshake with the core, halt cause and step hit
// ------------------------------------------------
`timescale 1ns/1ps

module debug_halt_ctrl import debug_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               halt_wr_i,
  input  logic               resume_wr_i,
  input  logic               ssth_clr_i,
  input  logic               debug_halt_i,
  input  logic               debug_resume_i,
  input  logic               trap_i,
  input  logic               dbg_ack_i,
  input  logic [CAUSE_W-1:0] exc_cause_i,
  input  logic               sste_i,
  output logic               dbg_req_o,
  output logic               stall_o,
  output logic               debug_halted_o,
  output logic [CAUSE_W-1:0] cause_o,
  output logic               ssth_o
);

  halt_state_e        state_q, state_n;
  logic [CAUSE_W-1:0] cause_q, cause_n;
  logic               ssth_q, ssth_n;
  logic               resume;

  assign resume = resume_wr_i | debug_resume_i; // bus or pin

  always_comb begin
    state_n        = state_q;
    dbg_req_o      = 1'b0;
    stall_o        = 1'b0;
    debug_halted_o = 1'b0;
    cause_n        = cause_q;
    ssth_n         = ssth_q;

    case (state_q)
      RUNNING: begin
        ssth_n = 1'b0;
        if (halt_wr_i | debug_halt_i | trap_i) begin
          dbg_req_o = 1'b1;  // request in the same cycle
          state_n   = HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = sste_i;
          end else begin
            cause_n = DBG_CAUSE_HALT;
          end
        end
      end
      HALT_REQ: begin
        dbg_req_o = 1'b1;    // held until ack
        if (dbg_ack_i)
          state_n = HALT;
        if (resume)
          state_n = RUNNING; // cancel
      end
      HALT: begin
        debug_halted_o = 1'b1;
        stall_o        = !resume; // release the core right away
        if (resume)
          state_n = RUNNING;
      end
      default: state_n = RUNNING;
    endcase

    if (ssth_clr_i)
      ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUNNING;
      cause_q <= DBG_CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign cause_o = cause_q;
  assign ssth_o  = ssth_q;

  // request stays up until the core acks or a resume cancels it
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_req_o && !dbg_ack_i && !resume |=> dbg_req_o)
    else $error("halt request dropped before acknowledge");

  a_halt_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(debug_halted_o) |-> $past(dbg_ack_i))
    else $error("core halted without an acknowledge");

endmodule

// File: verilog/debug_pc_track.sv
// ------------------------------------------------
// picks npc and ppc from the pipeline pcs seen at halt
// ------------------------------------------------
`timescale 1ns/1ps

module debug_pc_track import debug_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DBG_DATA_W-1:0] pc_if_i,
  input  logic [DBG_DATA_W-1:0] pc_id_i,
  input  logic [DBG_DATA_W-1:0] pc_ex_i,
  input  logic                  dbg_ack_i,
  input  logic                  branch_in_ex_i,
  input  logic                  branch_taken_i,
  input  logic                  data_load_event_i,
  input  logic                  instr_valid_id_i,
  input  logic                  jump_req_i,
  output logic [DBG_DATA_W-1:0] npc_o,
  output logic [DBG_DATA_W-1:0] ppc_o
);

  pc_track_e state_q, state_n;

  always_comb begin
    state_n = state_q;
    npc_o   = pc_if_i;
    ppc_o   = pc_id_i;

    case (state_q)
      IFID: ;                  // defaults above
      IFEX: ppc_o = pc_ex_i;
      IDEX: begin
        npc_o = pc_id_i;
        ppc_o = pc_ex_i;
        if (jump_req_i)
          state_n = IFEX;      // id stage flushed by the jump
      end
      default: state_n = IFID;
    endcase

    // pipeline snapshot at the halt ack
    if (dbg_ack_i) begin
      if (branch_in_ex_i)
        state_n = branch_taken_i ? IFEX : IDEX;
      else if (data_load_event_i)
        state_n = instr_valid_id_i ? IDEX : IFEX;
      else
        state_n = IFID;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state_q <= IFID;
    else
      state_q <= state_n;
  end

  // state moves only on the edge after an ack or a jump
  a_state_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != $past(state_q)) |-> ($past(dbg_ack_i) || $past(jump_req_i)))
    else $error("pc tracker moved without an ack or a jump");

endmodule

// File: verilog/debug_rdata_mux.sv
// ------------------------------------------------
// builds debug register words and returns read data with rvalid
// ------------------------------------------------
`timescale 1ns/1ps

module debug_rdata_mux import debug_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  gnt_i,
  input  rdata_sel_e            rdata_sel_i,
  input  logic [4:0]            addr_idx_i,
  input  settings_t             settings_i,
  input  logic                  halted_i,
  input  logic                  sleeping_i,
  input  logic                  ssth_i,
  input  logic [CAUSE_W-1:0]    cause_i,
  input  logic [DBG_DATA_W-1:0] npc_i,
  input  logic [DBG_DATA_W-1:0] ppc_i,
  input  logic [DBG_DATA_W-1:0] regfile_rdata_i,
  output logic                  debug_rvalid_o,
  output logic [DBG_DATA_W-1:0] debug_rdata_o
);

  logic [DBG_DATA_W-1:0] dbga_word;   // always-accessible registers
  logic [DBG_DATA_W-1:0] dbgs_word;   // npc or ppc

  always_comb begin
    dbga_word = '0;                   // bp control words read zero too
    case (addr_idx_i)
      REG_CTRL: begin
        dbga_word[CTRL_HALT_BIT] = halted_i;
        dbga_word[CTRL_SSTE_BIT] = settings_i.sste;
      end
      REG_HIT: begin
        dbga_word[HIT_SLEEP_BIT] = sleeping_i;
        dbga_word[HIT_SSTH_BIT]  = ssth_i;
      end
      REG_IE: begin
        dbga_word[IE_ECALL_BIT]   = settings_i.ecall;
        dbga_word[IE_ELSU_HI_BIT] = settings_i.elsu;
        dbga_word[IE_ELSU_LO_BIT] = settings_i.elsu;
        dbga_word[IE_EBRK_BIT]    = settings_i.ebrk;
        dbga_word[IE_EILL_BIT]    = settings_i.eill;
      end
      REG_CAUSE: begin
        dbga_word[DBG_DATA_W-1] = cause_i[CAUSE_W-1]; // interrupt flag on top
        dbga_word[CAUSE_W-2:0]  = cause_i[CAUSE_W-2:0];
      end
      default: ;
    endcase
  end

  assign dbgs_word = (addr_idx_i[0] == REG_PPC[0]) ? ppc_i : npc_i;

  always_comb begin
    case (rdata_sel_i)
      RD_GPR:  debug_rdata_o = regfile_rdata_i;
      RD_DBGA: debug_rdata_o = dbga_word;
      RD_DBGS: debug_rdata_o = dbgs_word;
      default: debug_rdata_o = '0;
    endcase
  end

  // rvalid one cycle after every grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      debug_rvalid_o <= 1'b0;
    else
      debug_rvalid_o <= gnt_i;
  end

endmodule

// File: verilog/debug_unit.sv
// ------------------------------------------------
// debug unit top, connects decoder, halt control, pc tracker, read mux
// ------------------------------------------------
`timescale 1ns/1ps

module debug_unit import debug_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // debugger bus
  input  logic                  debug_req_i,
  input  logic                  debug_we_i,
  input  logic [DBG_ADDR_W-1:0] debug_addr_i,
  input  logic [DBG_DATA_W-1:0] debug_wdata_i,
  output logic                  debug_gnt_o,
  output logic                  debug_rvalid_o,
  output logic [DBG_DATA_W-1:0] debug_rdata_o,
  output logic                  debug_halted_o,
  input  logic                  debug_halt_i,
  input  logic                  debug_resume_i,
  // core control
  output settings_t             settings_o,
  input  logic                  trap_i,
  input  logic [CAUSE_W-1:0]    exc_cause_i,
  output logic                  stall_o,
  output logic                  dbg_req_o,
  input  logic                  dbg_ack_i,
  // register file
  output logic                  regfile_rreq_o,
  output logic [GPR_ADDR_W-1:0] regfile_raddr_o,
  input  logic [DBG_DATA_W-1:0] regfile_rdata_i,
  output logic                  regfile_wreq_o,
  output logic [GPR_ADDR_W-1:0] regfile_waddr_o,
  output logic [DBG_DATA_W-1:0] regfile_wdata_o,
  // pipeline state for npc/ppc
  input  logic [DBG_DATA_W-1:0] pc_if_i,
  input  logic [DBG_DATA_W-1:0] pc_id_i,
  input  logic [DBG_DATA_W-1:0] pc_ex_i,
  input  logic                  data_load_event_i,
  input  logic                  instr_valid_id_i,
  input  logic                  sleeping_i,
  input  logic                  branch_in_ex_i,
  input  logic                  branch_taken_i,
  output logic                  jump_req_o,
  output logic [DBG_DATA_W-1:0] jump_addr_o
);

  rdata_sel_e            rdata_sel;
  logic [4:0]            addr_idx;
  logic                  halt_wr, resume_wr, ssth_clr;
  logic [CAUSE_W-1:0]    cause;
  logic                  ssth;
  logic [DBG_DATA_W-1:0] npc, ppc;

  debug_access_decode u_decode (
    .clk(clk), .rst_n(rst_n),
    .debug_req_i(debug_req_i), .debug_we_i(debug_we_i),
    .debug_addr_i(debug_addr_i), .debug_wdata_i(debug_wdata_i),
    .halted_i(debug_halted_o), .debug_gnt_o(debug_gnt_o),
    .rdata_sel_o(rdata_sel), .addr_idx_o(addr_idx), .settings_o(settings_o),
    .halt_wr_o(halt_wr), .resume_wr_o(resume_wr), .ssth_clr_o(ssth_clr),
    .jump_req_o(jump_req_o), .jump_addr_o(jump_addr_o),
    .regfile_rreq_o(regfile_rreq_o), .regfile_raddr_o(regfile_raddr_o),
    .regfile_wreq_o(regfile_wreq_o), .regfile_waddr_o(regfile_waddr_o),
    .regfile_wdata_o(regfile_wdata_o)
  );

  debug_halt_ctrl u_halt (
    .clk(clk), .rst_n(rst_n),
    .halt_wr_i(halt_wr), .resume_wr_i(resume_wr), .ssth_clr_i(ssth_clr),
    .debug_halt_i(debug_halt_i), .debug_resume_i(debug_resume_i),
    .trap_i(trap_i), .dbg_ack_i(dbg_ack_i), .exc_cause_i(exc_cause_i),
    .sste_i(settings_o.sste),
    .dbg_req_o(dbg_req_o), .stall_o(stall_o), .debug_halted_o(debug_halted_o),
    .cause_o(cause), .ssth_o(ssth)
  );

  debug_pc_track u_pc (
    .clk(clk), .rst_n(rst_n),
    .pc_if_i(pc_if_i), .pc_id_i(pc_id_i), .pc_ex_i(pc_ex_i),
    .dbg_ack_i(dbg_ack_i), .branch_in_ex_i(branch_in_ex_i),
    .branch_taken_i(branch_taken_i), .data_load_event_i(data_load_event_i),
    .instr_valid_id_i(instr_valid_id_i), .jump_req_i(jump_req_o),
    .npc_o(npc), .ppc_o(ppc)
  );

  debug_rdata_mux u_rdata (
    .clk(clk), .rst_n(rst_n),
    .gnt_i(debug_gnt_o), .rdata_sel_i(rdata_sel), .addr_idx_i(addr_idx),
    .settings_i(settings_o), .halted_i(debug_halted_o), .sleeping_i(sleeping_i),
    .ssth_i(ssth), .cause_i(cause), .npc_i(npc), .ppc_i(ppc),
    .regfile_rdata_i(regfile_rdata_i),
    .debug_rvalid_o(debug_rvalid_o), .debug_rdata_o(debug_rdata_o)
  );

endmodule

// File: verification/debug_unit_tb.sv
// ------------------------------------------------
// testbench for the debug unit against a scoreboard model
// runs halt, register file, trap and pc tracking sequences
// ------------------------------------------------
`timescale 1ns/1ps

module debug_unit_tb import debug_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_SET      = 8;   // settings round trips
  localparam int N_GPR      = 8;   // gpr writes, then reads
  localparam int N_PC       = 6;   // halt/jump rounds
  localparam int ACC_CYC    = 3;   // worst case per bus access
  localparam int HALT_CYC   = 12;  // ack delay plus checks
  localparam int TEST_CYC   = ACC_CYC * (14 + N_SET * 4 + N_GPR * 2 + N_PC * 5) +
                              (N_PC + 2) * HALT_CYC + 20;
  localparam int MARGIN_CYC = 100;

  localparam logic [1:0] TR_IFID = 2'd0;
  localparam logic [1:0] TR_IFEX = 2'd1;
  localparam logic [1:0] TR_IDEX = 2'd2;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  debug_req_i, debug_we_i;
  logic [DBG_ADDR_W-1:0] debug_addr_i;
  logic [DBG_DATA_W-1:0] debug_wdata_i;
  logic                  debug_gnt_o, debug_rvalid_o, debug_halted_o;
  logic [DBG_DATA_W-1:0] debug_rdata_o;
  logic                  debug_halt_i, debug_resume_i;
  settings_t             settings_o;
  logic                  trap_i, dbg_ack_i, stall_o, dbg_req_o;
  logic [CAUSE_W-1:0]    exc_cause_i;
  logic                  regfile_rreq_o, regfile_wreq_o;
  logic [GPR_ADDR_W-1:0] regfile_raddr_o, regfile_waddr_o;
  logic [DBG_DATA_W-1:0] regfile_rdata_i, regfile_wdata_o;
  logic [DBG_DATA_W-1:0] pc_if_i, pc_id_i, pc_ex_i;
  logic                  data_load_event_i, instr_valid_id_i, sleeping_i;
  logic                  branch_in_ex_i, branch_taken_i;
  logic                  jump_req_o;
  logic [DBG_DATA_W-1:0] jump_addr_o;

  // scoreboard copy of the unit state
  logic        m_halted, m_sste, m_ecall, m_elsu, m_ebrk, m_eill, m_ssth;
  logic [5:0]  m_cause;
  logic [1:0]  m_track;
  logic [31:0] m_jump_addr;
  logic [31:0] gpr_exp [32];

  logic [31:0] rf [32];            // core register file
  logic [31:0] exp_q [$];          // expected read data queued at grant
  logic        rreq_q [$];         // expected regfile_rreq_o in rvalid cycle
  integer      seed = 32'he1b8_f198;
  int          issue_cnt = 0;
  int          rvalid_cnt = 0;
  int          jump_cnt = 0;
  logic        gnt_prev = 1'b0;

  debug_unit DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------
  // register file model
  // ------------------------------------------------
  always @(posedge clk) begin
    if (regfile_wreq_o)
      rf[regfile_waddr_o] <= regfile_wdata_o;
  end

  assign regfile_rdata_i = rf[regfile_raddr_o];  // combinational read

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [31:0] fill_word(input logic [4:0] a);
    return {8'hA5, 3'b0, a, 3'b0, a, 3'b0, a};
  endfunction

  function automatic logic [14:0] dbg_addr(input logic [5:0] region, input logic [4:0] idx);
    return {1'b0, region, 1'b0, idx, 2'b00};
  endfunction

  // ------------------------------------------------
  // reference model
  // ------------------------------------------------
  function automatic logic [1:0] track_after_ack(input logic br, input logic tk,
                                                 input logic ld, input logic vid);
    if (br)
      return tk ? TR_IFEX : TR_IDEX;   // branch in ex decides
    if (ld)
      return vid ? TR_IDEX : TR_IFEX;
    return TR_IFID;
  endfunction

  function automatic logic [31:0] track_npc();
    return (m_track == TR_IDEX) ? pc_id_i : pc_if_i;
  endfunction

  function automatic logic [31:0] track_ppc();
    return (m_track == TR_IFID) ? pc_id_i : pc_ex_i;
  endfunction

  function automatic settings_t model_settings();
    settings_t s;
    s.sste  = m_sste;
    s.ecall = m_ecall;
    s.elsu  = m_elsu;
    s.ebrk  = m_ebrk;
    s.eill  = m_eill;
    return s;
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [14:0] addr);
    logic [5:0]  region;
    logic [4:0]  idx;
    logic [31:0] d;
    region = addr[13:8];
    idx    = addr[6:2];
    d      = '0;
    if (!addr[14]) begin            // csr region reads zero
      case (region)
        REGION_DBG_ALWAYS: begin
          case (idx)
            REG_CTRL: begin
              d[16] = m_halted;
              d[0]  = m_sste;
            end
            REG_HIT: begin
              d[16] = sleeping_i;
              d[0]  = m_ssth;
            end
            REG_IE: begin
              d[11] = m_ecall;
              d[7]  = m_elsu;
              d[5]  = m_elsu;
              d[3]  = m_ebrk;
              d[2]  = m_eill;
            end
            REG_CAUSE: begin
              d[31]  = m_cause[5];
              d[4:0] = m_cause[4:0];
            end
            default: ;                // breakpoint words
          endcase
        end
        REGION_DBG_HALTED: if (m_halted) d = idx[0] ? track_ppc() : track_npc();
        REGION_GPR:        if (m_halted) d = gpr_exp[idx];
        default: ;
      endcase
    end
    return d;
  endfunction

  // state update for a write at the end of its grant cycle
  function automatic void model_write(input logic [14:0] addr, input logic [31:0] wd);
    logic [5:0] region;
    logic [4:0] idx;
    region = addr[13:8];
    idx    = addr[6:2];
    if (addr[14])
      return;
    if (region == REGION_DBG_ALWAYS) begin
      if (idx == REG_CTRL) begin
        if (wd[16] && !m_halted)
          m_cause = DBG_CAUSE_HALT;   // halt pending until ack
        if (!wd[16] && m_halted) begin
          m_halted = 1'b0;
          m_ssth   = 1'b0;
        end
        m_sste = wd[0];
      end else if (idx == REG_HIT) begin
        if (wd[0])
          m_ssth = 1'b0;              // write 1 clears
      end else if (idx == REG_IE) begin
        m_ecall = wd[11];
        m_elsu  = wd[7] | wd[5];
        m_ebrk  = wd[3];
        m_eill  = wd[2];
      end
    end else if (region == REGION_DBG_HALTED && m_halted && idx == REG_NPC) begin
      m_jump_addr = wd;
      if (m_track == TR_IDEX)
        m_track = TR_IFEX;            // jump flushes id
    end else if (region == REGION_GPR && m_halted) begin
      gpr_exp[idx] = wd;
    end
  endfunction

  // ------------------------------------------------
  // bus driver called on a rising edge
  // ------------------------------------------------
  task automatic bus_access(input logic we, input logic [14:0] addr, input logic [31:0] wd);
    debug_req_i   <= 1'b1;
    debug_we_i    <= we;
    debug_addr_i  <= addr;
    debug_wdata_i <= wd;
    exp_q.push_back(we ? 32'h0 : expected_rdata(addr));   // writes return zero
    rreq_q.push_back(!we && !addr[14] && addr[13:8] == REGION_GPR && m_halted);
    issue_cnt++;
    @(posedge clk);
    debug_req_i <= 1'b0;
    if (we)
      model_write(addr, wd);
    while (rvalid_cnt != issue_cnt)
      @(posedge clk);
  endtask

  // hold off the ack, then acknowledge with a random pipeline snapshot
  task automatic ack_halt(input logic [2:0] dly);
    logic [31:0] r;
    repeat (dly) begin
      @(negedge clk);
      assert (dbg_req_o && !debug_halted_o)
        else abort_run("halt request dropped before acknowledge");
      @(posedge clk);
    end
    r = rand32();
    dbg_ack_i         <= 1'b1;
    branch_in_ex_i    <= r[0];
    branch_taken_i    <= r[1];
    data_load_event_i <= r[2];
    instr_valid_id_i  <= r[3];
    pc_if_i           <= rand32();
    pc_id_i           <= rand32();
    pc_ex_i           <= rand32();
    m_track = track_after_ack(r[0], r[1], r[2], r[3]);
    @(negedge clk);
    assert (dbg_req_o && !debug_halted_o)
      else abort_run("halt request not up in the acknowledge cycle");
    @(posedge clk);
    dbg_ack_i <= 1'b0;
    m_halted = 1'b1;
    @(negedge clk);
    assert (debug_halted_o && stall_o && !dbg_req_o)
      else abort_run("core not halted after acknowledge");
    @(posedge clk);
  endtask

  task automatic check_settings();
    @(negedge clk);
    assert (settings_o == model_settings())
      else abort_run($sformatf("FAIL settings_o got %h expected %h",
                               settings_o, model_settings()));
    @(posedge clk);
  endtask

  // ------------------------------------------------
  // comparing process samples mid cycle
  // ------------------------------------------------
  always @(negedge clk) begin
    logic [31:0] exp_data;
    logic        rreq_e;
    if (rst_n) begin
      assert (debug_gnt_o == debug_req_i)
        else abort_run($sformatf("FAIL debug_gnt_o got %h expected %h",
                                 debug_gnt_o, debug_req_i));
      assert (debug_rvalid_o == gnt_prev)
        else abort_run("rvalid did not follow the grant by one cycle");
      if (debug_rvalid_o) begin
        assert (exp_q.size() != 0) else abort_run("rvalid without a pending access");
        exp_data = exp_q.pop_front();
        rreq_e   = rreq_q.pop_front();
        assert (debug_rdata_o == exp_data)
          else abort_run($sformatf("FAIL debug_rdata_o got %h expected %h",
                                   debug_rdata_o, exp_data));
        assert (regfile_rreq_o == rreq_e)
          else abort_run($sformatf("FAIL regfile_rreq_o got %h expected %h",
                                   regfile_rreq_o, rreq_e));
        rvalid_cnt++;
      end else begin
        assert (debug_rdata_o == '0)
          else abort_run($sformatf("FAIL debug_rdata_o got %h expected 0", debug_rdata_o));
        assert (!regfile_rreq_o) else abort_run("register read request outside rvalid");
      end
      if (jump_req_o) begin
        jump_cnt++;
        assert (jump_addr_o == m_jump_addr)
          else abort_run($sformatf("FAIL jump_addr_o got %h expected %h",
                                   jump_addr_o, m_jump_addr));
      end
      gnt_prev = debug_gnt_o;
    end
  end

  initial begin
    #(CLK_PERIOD * (TEST_CYC + MARGIN_CYC));
    abort_run("watchdog timeout, the run did not complete");
  end

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------
  initial begin
    logic [31:0] r, w;
    logic [4:0]  widx [N_GPR];
    int          jc;
    rst_n <= 1'b0;
    debug_req_i <= 1'b0;
    debug_we_i <= 1'b0;
    debug_addr_i <= '0;
    debug_wdata_i <= '0;
    debug_halt_i <= 1'b0;
    debug_resume_i <= 1'b0;
    trap_i <= 1'b0;
    exc_cause_i <= '0;
    dbg_ack_i <= 1'b0;
    pc_if_i <= '0;
    pc_id_i <= '0;
    pc_ex_i <= '0;
    data_load_event_i <= 1'b0;
    instr_valid_id_i <= 1'b0;
    sleeping_i <= 1'b0;
    branch_in_ex_i <= 1'b0;
    branch_taken_i <= 1'b0;
    {m_halted, m_sste, m_ecall, m_elsu, m_ebrk, m_eill, m_ssth} = '0;
    m_cause     = DBG_CAUSE_HALT;
    m_track     = TR_IFID;
    m_jump_addr = '0;
    for (int i = 0; i < 32; i++) begin
      rf[i] <= fill_word(i[4:0]);
      gpr_exp[i] = fill_word(i[4:0]);
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // reset values
    @(negedge clk);
    assert (!debug_rvalid_o && !dbg_req_o && !stall_o && !debug_halted_o &&
            !jump_req_o && !regfile_rreq_o && !regfile_wreq_o)
      else abort_run("control outputs not low after reset");
    @(posedge clk);
    check_settings();
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CAUSE), '0);

    // settings round trip while the core runs
    for (int i = 0; i < N_SET; i++) begin
      bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_IE), rand32());
      bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_IE), '0);
      w = rand32();
      w[16] = 1'b0;                  // no halt here
      bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), w);
      bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);
      check_settings();
    end

    // halt through ctrl
    bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h0001_0000);
    r = rand32();
    ack_halt(r[2:0]);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CAUSE), '0);

    // register file while halted
    for (int i = 0; i < N_GPR; i++) begin
      r = rand32();
      widx[i] = r[4:0];
      bus_access(1'b1, dbg_addr(REGION_GPR, widx[i]), rand32());
    end
    for (int i = 0; i < N_GPR; i++)
      bus_access(1'b0, dbg_addr(REGION_GPR, widx[i]), '0);

    // resume, then a gpr read while running gives zero
    bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);
    @(negedge clk);
    assert (!debug_halted_o && !stall_o) else abort_run("core still halted after resume");
    @(posedge clk);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);
    bus_access(1'b0, dbg_addr(REGION_GPR, widx[0]), '0);

    // trap with single step
    bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), 32'h1);
    r = rand32();
    trap_i      <= 1'b1;
    exc_cause_i <= r[5:0];
    sleeping_i  <= r[8];
    m_cause = r[5:0];
    m_ssth  = m_sste;
    @(posedge clk);
    trap_i <= 1'b0;
    ack_halt(r[11:9]);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_CAUSE), '0);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_HIT), '0);
    bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_HIT), 32'h1);
    bus_access(1'b0, dbg_addr(REGION_DBG_ALWAYS, REG_HIT), '0);
    bus_access(1'b1, dbg_addr(REGION_DBG_ALWAYS, REG_CTRL), '0);

    // pc tracking and jump with halt and resume by pin
    for (int i = 0; i < N_PC; i++) begin
      debug_halt_i <= 1'b1;
      m_cause = DBG_CAUSE_HALT;
      @(negedge clk);
      assert (dbg_req_o) else abort_run("halt pin did not raise the halt request");
      @(posedge clk);
      debug_halt_i <= 1'b0;
      r = rand32();
      ack_halt(r[2:0]);
      bus_access(1'b0, dbg_addr(REGION_DBG_HALTED, REG_NPC), '0);
      bus_access(1'b0, dbg_addr(REGION_DBG_HALTED, REG_PPC), '0);
      jc = jump_cnt;
      bus_access(1'b1, dbg_addr(REGION_DBG_HALTED, REG_NPC), rand32());
      assert (jump_cnt == jc + 1) else abort_run("npc write did not give one jump pulse");
      bus_access(1'b0, dbg_addr(REGION_DBG_HALTED, REG_NPC), '0);
      bus_access(1'b0, dbg_addr(REGION_DBG_HALTED, REG_PPC), '0);
      debug_resume_i <= 1'b1;
      @(negedge clk);
      assert (debug_halted_o && !stall_o)
        else abort_run("stall not released in the resume cycle");
      @(posedge clk);
      debug_resume_i <= 1'b0;
      m_halted = 1'b0;
      m_ssth   = 1'b0;
      @(negedge clk);
      assert (!debug_halted_o && !stall_o) else abort_run("resume pin did not release the core");
      @(posedge clk);
    end
    assert (jump_cnt == N_PC) else abort_run("jump pulse count wrong at end of run");

    $display("sim passed");
    $finish;
  end

endmodule

// File: debug_unit.f
verilog/debug_pkg.sv
verilog/debug_access_decode.sv
verilog/debug_halt_ctrl.sv
verilog/debug_pc_track.sv
verilog/debug_rdata_mux.sv
verilog/debug_unit.sv
verification/debug_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the debug unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f debug_unit.f --top-module debug_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

./obj_dir/Vdebug_unit_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
